//--- rtl/cache_pkg.sv
package cache_pkg;

    // 32-byte line, so five offset bits
    parameter int s_offset = 5;

    // One full cache line (8 words of 32 bits)
    typedef logic [8*(2**s_offset)-1:0] line_t;

    // One enable per byte of a line
    typedef logic [2**s_offset-1:0] byte_mask_t;

    // Data array input source
    typedef enum logic {
        mem_wdata,
        ca_rdata
    } datamux_sel_t;

    // Memory-side address source
    typedef enum logic {
        mem_addr,
        tag_addr
    } addrmux_sel_t;

endpackage

//--- rtl/cache_ctrl_if.sv
`timescale 1ns/100ps

interface cache_ctrl_if #(
    parameter int way_deg = 1
);

    localparam int way_count = 2 ** way_deg;

    // Datapath status
    logic                     hit;
    logic [way_deg-1:0]       hit_way;
    logic [way_deg-1:0]       lru_way;
    logic                     lru_dirty;
    logic [way_count-2:0]     lru_out;

    // Per-way loads, one bit per way
    logic [way_count-1:0]     load_tag;
    logic [way_count-1:0]     set_valid;
    logic [way_count-1:0]     load_dirty;
    logic [way_count-1:0]     dirty_in;
    logic [way_count-1:0]     load_data;

    // Shared controls
    logic [way_count-2:0]     lru_in;
    logic                     load_lru;
    cache_pkg::datamux_sel_t  datamux_sel;
    cache_pkg::addrmux_sel_t  addrmux_sel;

    modport ctrl (
        input  hit, hit_way, lru_way, lru_dirty, lru_out,
        output load_tag, set_valid, load_dirty, dirty_in, load_data,
        output lru_in, load_lru, datamux_sel, addrmux_sel
    );

    modport dp (
        output hit, hit_way, lru_way, lru_dirty, lru_out,
        input  load_tag, set_valid, load_dirty, dirty_in, load_data,
        input  lru_in, load_lru, datamux_sel, addrmux_sel
    );

endinterface

//--- rtl/cache_array.sv
`timescale 1ns/100ps

module cache_array #(
    parameter int  s_index   = 3,
    parameter type payload_t = logic
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               load,
    input  logic [s_index-1:0] index,
    input  payload_t           datain,
    output payload_t           dataout
);

    localparam int num_sets = 2 ** s_index;

    payload_t entries [num_sets];

    // All sets start invalid, clean and with LRU bits at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                entries[s] <= '0;
            end
        end else if (load) begin
            entries[index] <= datain;
        end
    end

    // Combinational read of the addressed set
    assign dataout = entries[index];

endmodule

//--- rtl/cache_data_array.sv
`timescale 1ns/100ps

module cache_data_array #(
    parameter int s_index = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::byte_mask_t write_en,
    input  logic [s_index-1:0]    index,
    input  cache_pkg::line_t      datain,
    output cache_pkg::line_t      dataout
);

    localparam int num_sets  = 2 ** s_index;
    localparam int num_bytes = $bits(cache_pkg::byte_mask_t);

    cache_pkg::line_t lines [num_sets];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                lines[s] <= '0;
            end
        end else begin
            // Only the enabled bytes change
            for (int b = 0; b < num_bytes; b++) begin
                if (write_en[b]) begin
                    lines[index][8*b +: 8] <= datain[8*b +: 8];
                end
            end
        end
    end

    assign dataout = lines[index];

endmodule

//--- rtl/cache_datapath.sv
`timescale 1ns/100ps

module cache_datapath #(
    parameter int s_index = 3,
    parameter int way_deg = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           mem_addr,
    input  cache_pkg::line_t      mem_wdata,
    input  cache_pkg::byte_mask_t mem_byte_enable,
    output cache_pkg::line_t      mem_rdata,
    input  cache_pkg::line_t      ca_rdata,
    output cache_pkg::line_t      ca_wdata,
    output logic [31:0]           ca_addr,
    cache_ctrl_if.dp              ctl
);

    localparam int s_offset  = cache_pkg::s_offset;
    localparam int s_tag     = 32 - s_offset - s_index;
    localparam int way_count = 2 ** way_deg;

    logic [s_index-1:0]    set_index;
    logic [s_tag-1:0]      tag;
    logic [s_tag-1:0]      tag_out [way_count];
    logic [way_count-1:0]  valid_out;
    logic [way_count-1:0]  dirty_out;
    logic [way_count-1:0]  way_match;
    cache_pkg::line_t      data_in;
    cache_pkg::line_t      data_out [way_count];
    cache_pkg::byte_mask_t data_write_en [way_count];

    // Address split
    assign set_index = mem_addr[s_index+s_offset-1:s_offset];
    assign tag       = mem_addr[31 -: s_tag];

    for (genvar w = 0; w < way_count; w++) begin : g_way
        cache_array #(.s_index(s_index), .payload_t(logic [s_tag-1:0])) i_tag_array (
            .clk     (clk),
            .reset   (reset),
            .load    (ctl.load_tag[w]),
            .index   (set_index),
            .datain  (tag),
            .dataout (tag_out[w])
        );

        // Valid bits are only ever set
        cache_array #(.s_index(s_index), .payload_t(logic)) i_valid_array (
            .clk     (clk),
            .reset   (reset),
            .load    (ctl.set_valid[w]),
            .index   (set_index),
            .datain  (1'b1),
            .dataout (valid_out[w])
        );

        cache_array #(.s_index(s_index), .payload_t(logic)) i_dirty_array (
            .clk     (clk),
            .reset   (reset),
            .load    (ctl.load_dirty[w]),
            .index   (set_index),
            .datain  (ctl.dirty_in[w]),
            .dataout (dirty_out[w])
        );

        cache_data_array #(.s_index(s_index)) i_data_array (
            .clk      (clk),
            .reset    (reset),
            .write_en (data_write_en[w]),
            .index    (set_index),
            .datain   (data_in),
            .dataout  (data_out[w])
        );

        assign way_match[w] = valid_out[w] && (tag_out[w] == tag);
    end

    cache_array #(.s_index(s_index), .payload_t(logic [way_count-2:0])) i_lru_array (
        .clk     (clk),
        .reset   (reset),
        .load    (ctl.load_lru),
        .index   (set_index),
        .datain  (ctl.lru_in),
        .dataout (ctl.lru_out)
    );

    // Hit compare
    always_comb begin
        ctl.hit_way = '0;
        for (int w = 0; w < way_count; w++) begin
            if (way_match[w]) begin
                ctl.hit_way = way_deg'(w);
            end
        end
    end

    assign ctl.hit = |way_match;

    // Tree walk from the root; each node bit points toward the older half
    always_comb begin : victim_decode
        int node;
        node = 0;
        for (int d = 0; d < way_deg; d++) begin
            ctl.lru_way[way_deg-1-d] = ctl.lru_out[node];
            node = 2 * node + 1 + int'(ctl.lru_out[node]);
        end
    end

    assign ctl.lru_dirty = dirty_out[ctl.lru_way];

    // Data input select and per-way byte enables
    always_comb begin
        unique case (ctl.datamux_sel)
            cache_pkg::mem_wdata: data_in = mem_wdata;
            cache_pkg::ca_rdata:  data_in = ca_rdata;
            default:              data_in = '0;
        endcase

        for (int w = 0; w < way_count; w++) begin
            if (!ctl.load_data[w]) begin
                data_write_en[w] = '0;
            end else if (ctl.datamux_sel == cache_pkg::ca_rdata) begin
                data_write_en[w] = '1;
            end else begin
                data_write_en[w] = mem_byte_enable;
            end
        end
    end

    assign mem_rdata = data_out[ctl.hit_way];
    assign ca_wdata  = data_out[ctl.lru_way];

    // Line-aligned memory address, request or rebuilt victim
    always_comb begin
        unique case (ctl.addrmux_sel)
            cache_pkg::mem_addr: ca_addr = {mem_addr[31:s_offset], {s_offset{1'b0}}};
            cache_pkg::tag_addr: ca_addr = {tag_out[ctl.lru_way], set_index, {s_offset{1'b0}}};
            default:             ca_addr = '0;
        endcase
    end

    // A tag lives in at most one way of a set
    a_single_match: assert property (@(posedge clk) disable iff (reset)
        $onehot0(way_match));

    // Selects from control must be defined whenever something is written
    a_mux_legal: assert property (@(posedge clk) disable iff (reset)
        (|{ctl.load_data, ctl.load_tag}) |->
            !$isunknown(ctl.datamux_sel) && !$isunknown(ctl.addrmux_sel));

endmodule

//--- rtl/cache_control.sv
`timescale 1ns/100ps

module cache_control #(
    parameter int way_deg = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        mem_read,
    input  logic        mem_write,
    output logic        mem_resp,
    output logic        ca_read,
    output logic        ca_write,
    input  logic        ca_resp,
    cache_ctrl_if.ctrl  ctl
);

    typedef enum logic [1:0] {
        st_compare,
        st_write_back,
        st_fill
    } state_t;

    state_t state;
    state_t next_state;
    logic   request;

    assign request = mem_read || mem_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_compare;
        end else begin
            state <= next_state;
        end
    end

    // New LRU bits: every node on the hit way's path points away from it
    always_comb begin : lru_update
        int node;
        node = 0;
        ctl.lru_in = ctl.lru_out;
        for (int d = 0; d < way_deg; d++) begin
            ctl.lru_in[node] = ~ctl.hit_way[way_deg-1-d];
            node = 2 * node + 1 + int'(ctl.hit_way[way_deg-1-d]);
        end
    end

    always_comb begin
        next_state      = state;
        mem_resp        = 1'b0;
        ca_read         = 1'b0;
        ca_write        = 1'b0;
        ctl.load_tag    = '0;
        ctl.set_valid   = '0;
        ctl.load_dirty  = '0;
        ctl.dirty_in    = '0;
        ctl.load_data   = '0;
        ctl.load_lru    = 1'b0;
        ctl.datamux_sel = cache_pkg::mem_wdata;
        ctl.addrmux_sel = cache_pkg::mem_addr;

        unique case (state)
            st_compare: begin
                if (request && ctl.hit) begin
                    mem_resp     = 1'b1;
                    ctl.load_lru = 1'b1;
                    if (mem_write) begin
                        // Write hit merges bytes and marks the line dirty
                        ctl.load_data[ctl.hit_way]  = 1'b1;
                        ctl.load_dirty[ctl.hit_way] = 1'b1;
                        ctl.dirty_in[ctl.hit_way]   = 1'b1;
                    end
                end else if (request) begin
                    next_state = ctl.lru_dirty ? st_write_back : st_fill;
                end
            end

            st_write_back: begin
                ca_write        = 1'b1;
                ctl.addrmux_sel = cache_pkg::tag_addr;
                if (ca_resp) begin
                    next_state = st_fill;
                end
            end

            st_fill: begin
                ca_read         = 1'b1;
                ctl.datamux_sel = cache_pkg::ca_rdata;
                if (ca_resp) begin
                    // Victim way gets the new line, valid and clean
                    ctl.load_data[ctl.lru_way]  = 1'b1;
                    ctl.load_tag[ctl.lru_way]   = 1'b1;
                    ctl.set_valid[ctl.lru_way]  = 1'b1;
                    ctl.load_dirty[ctl.lru_way] = 1'b1;
                    next_state                  = st_compare;
                end
            end

            default: begin
                next_state = st_compare;
            end
        endcase
    end

    // A memory request stays up and unchanged until the memory answers
    a_mem_req_held: assert property (@(posedge clk) disable iff (reset)
        (ca_read || ca_write) && !ca_resp |=> $stable({ca_read, ca_write}));

    // The processor holds its request until the response pulse
    a_req_held: assert property (@(posedge clk) disable iff (reset)
        request && !mem_resp |=> request);

endmodule

//--- rtl/cache.sv
`timescale 1ns/100ps

module cache #(
    parameter int s_index = 3,
    parameter int way_deg = 1
) (
    input  logic                  clk,
    input  logic                  reset,

    // Processor side
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic [31:0]           mem_addr,
    input  cache_pkg::line_t      mem_wdata,
    input  cache_pkg::byte_mask_t mem_byte_enable,
    output cache_pkg::line_t      mem_rdata,
    output logic                  mem_resp,

    // Memory side
    output logic                  ca_read,
    output logic                  ca_write,
    output logic [31:0]           ca_addr,
    output cache_pkg::line_t      ca_wdata,
    input  cache_pkg::line_t      ca_rdata,
    input  logic                  ca_resp
);

    cache_ctrl_if #(.way_deg(way_deg)) ctl_if ();

    cache_control #(.way_deg(way_deg)) i_control (
        .clk       (clk),
        .reset     (reset),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_resp  (mem_resp),
        .ca_read   (ca_read),
        .ca_write  (ca_write),
        .ca_resp   (ca_resp),
        .ctl       (ctl_if.ctrl)
    );

    cache_datapath #(.s_index(s_index), .way_deg(way_deg)) i_datapath (
        .clk             (clk),
        .reset           (reset),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .mem_rdata       (mem_rdata),
        .ca_rdata        (ca_rdata),
        .ca_wdata        (ca_wdata),
        .ca_addr         (ca_addr),
        .ctl             (ctl_if.dp)
    );

endmodule

//--- testbench/cache_mem_model.sv
`timescale 1ns/100ps

module cache_mem_model #(
    parameter logic [31:0] seed      = 32'h1,
    parameter int          max_delay = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             ca_read,
    input  logic             ca_write,
    input  logic [31:0]      ca_addr,
    input  cache_pkg::line_t ca_wdata,
    output cache_pkg::line_t ca_rdata,
    output logic             ca_resp
);

    cache_pkg::line_t mem [logic [31:0]];
    logic [31:0]      rand_state;
    logic             busy;
    int               wait_cycles;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Lines never written read back as a pattern of their own address
    function automatic cache_pkg::line_t pattern_line(input logic [31:0] a);
        cache_pkg::line_t l;
        for (int w = 0; w < 8; w++) begin
            l[32*w +: 32] = (a + 32'(w)) * 32'h9e3779b9;
        end
        return l;
    endfunction

    initial begin
        ca_rdata    = '0;
        ca_resp     = 1'b0;
        rand_state  = seed;
        busy        = 1'b0;
        wait_cycles = 0;
    end

    // Answers one request after 1 to max_delay cycles
    always @(negedge clk) begin
        ca_resp = 1'b0;
        if (reset) begin
            busy = 1'b0;
        end else if (ca_read || ca_write) begin
            if (!busy) begin
                rand_state  = next_rand(rand_state);
                wait_cycles = 1 + int'(rand_state[31:24]) % max_delay;
                busy        = 1'b1;
            end
            wait_cycles--;
            if (wait_cycles == 0) begin
                busy    = 1'b0;
                ca_resp = 1'b1;
                if (ca_write) begin
                    mem[ca_addr] = ca_wdata;
                end else begin
                    ca_rdata = mem.exists(ca_addr) ? mem[ca_addr] : pattern_line(ca_addr);
                end
            end
        end
    end

endmodule

//--- testbench/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

    localparam int period      = 8;
    localparam int num_sets    = 8;
    localparam int num_trans   = 2000;
    localparam int watchdog_ns = (num_trans + 32) * 24 * period;

    logic                  clk;
    logic                  reset;
    logic                  mem_read;
    logic                  mem_write;
    logic [31:0]           mem_addr;
    cache_pkg::line_t      mem_wdata;
    cache_pkg::byte_mask_t mem_byte_enable;
    cache_pkg::line_t      mem_rdata;
    logic                  mem_resp;
    logic                  ca_read;
    logic                  ca_write;
    logic [31:0]           ca_addr;
    cache_pkg::line_t      ca_wdata;
    cache_pkg::line_t      ca_rdata;
    logic                  ca_resp;

    // Reference model of the cache state, two ways per set
    logic [23:0]      tag_m   [num_sets][2];
    logic             valid_m [num_sets][2];
    logic             dirty_m [num_sets][2];
    logic             lru_m   [num_sets];
    cache_pkg::line_t shadow  [logic [31:0]];
    int               checks;
    int               errors;

    cache i_cache (.*);

    cache_mem_model #(.seed(32'had68c79e), .max_delay(8)) i_mem (
        .clk(clk), .reset(reset), .ca_read(ca_read), .ca_write(ca_write), .ca_addr(ca_addr),
        .ca_wdata(ca_wdata), .ca_rdata(ca_rdata), .ca_resp(ca_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the cache stopped answering after %0d ns", watchdog_ns);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic cache_pkg::line_t pattern_line(input logic [31:0] a);
        cache_pkg::line_t l;
        for (int w = 0; w < 8; w++) begin
            l[32*w +: 32] = (a + 32'(w)) * 32'h9e3779b9;
        end
        return l;
    endfunction

    function automatic cache_pkg::line_t shadow_line(input logic [31:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return pattern_line(a);
    endfunction

    function automatic cache_pkg::line_t merge_bytes(input cache_pkg::line_t old,
            input cache_pkg::line_t wdata, input cache_pkg::byte_mask_t mask);
        cache_pkg::line_t l;
        l = old;
        for (int b = 0; b < 32; b++) begin
            if (mask[b]) l[8*b +: 8] = wdata[8*b +: 8];
        end
        return l;
    endfunction

    // Four tags per set keep the victim logic busy
    function automatic logic [31:0] make_addr(input logic [1:0] tag_lo, input logic [2:0] set,
            input logic [4:0] offset);
        return {22'h3a5c1, tag_lo, set, offset};
    endfunction

    task automatic check_line(input string name, input cache_pkg::line_t exp,
            input cache_pkg::line_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // One processor request, watched cycle by cycle until mem_resp
    task automatic run_access(input string name, input logic wr, input logic [31:0] addr,
            input cache_pkg::line_t wdata, input cache_pkg::byte_mask_t be, output logic missed);
        int          set;
        int          way;
        logic [23:0] tag;
        logic [31:0] line_addr;
        logic [31:0] victim_addr;
        logic        exp_miss;
        logic        exp_wb;
        logic        saw_read;
        logic        saw_write;
        set       = int'(addr[7:5]);
        tag       = addr[31:8];
        line_addr = {addr[31:5], 5'd0};
        way       = -1;
        for (int w = 0; w < 2; w++) begin
            if (valid_m[set][w] && tag_m[set][w] == tag) way = w;
        end
        exp_miss = (way < 0);
        exp_wb   = 1'b0;
        if (exp_miss) begin
            way         = int'(lru_m[set]);
            exp_wb      = valid_m[set][way] && dirty_m[set][way];
            victim_addr = {tag_m[set][way], addr[7:5], 5'd0};
        end
        saw_read  = 1'b0;
        saw_write = 1'b0;
        @(negedge clk);
        mem_read        = !wr;
        mem_write       = wr;
        mem_addr        = addr;
        mem_wdata       = wdata;
        mem_byte_enable = be;
        #2;
        // A hit answers in the cycle of the request
        if (!exp_miss) begin
            check_flag({name, " hit response"}, 1'b1, mem_resp);
        end
        while (!mem_resp) begin
            if (ca_write) begin
                check_flag({name, " write-back expected"}, exp_wb, 1'b1);
                check_flag({name, " fill before write-back"}, 1'b0, saw_read);
                check_addr({name, " write-back address"}, victim_addr, ca_addr);
                check_line({name, " write-back data"}, shadow_line(victim_addr), ca_wdata);
                saw_write = 1'b1;
            end
            if (ca_read) begin
                check_addr({name, " fill address"}, line_addr, ca_addr);
                saw_read = 1'b1;
            end
            @(negedge clk);
            #2;
        end
        check_flag({name, " ca_read at response"}, 1'b0, ca_read);
        check_flag({name, " ca_write at response"}, 1'b0, ca_write);
        check_flag({name, " fill seen"}, exp_miss, saw_read);
        check_flag({name, " write-back seen"}, exp_wb, saw_write);
        if (wr) begin
            shadow[line_addr] = merge_bytes(shadow_line(line_addr), wdata, be);
        end else begin
            check_line({name, " read data"}, shadow_line(line_addr), mem_rdata);
        end
        if (exp_miss) begin
            tag_m[set][way]   = tag;
            valid_m[set][way] = 1'b1;
            dirty_m[set][way] = 1'b0;
        end
        lru_m[set] = (way == 0);
        if (wr) dirty_m[set][way] = 1'b1;
        // Reports what the DUT did, seen as a fill on the memory side
        missed = saw_read;
    endtask

    initial begin : stimulus
        logic [31:0]           seed;
        logic                  missed;
        cache_pkg::line_t      wdata;
        cache_pkg::byte_mask_t be;
        seed            = 32'had68c79e;
        checks          = 0;
        errors          = 0;
        reset           = 1'b1;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_addr        = '0;
        mem_wdata       = '0;
        mem_byte_enable = '0;
        for (int s = 0; s < num_sets; s++) begin
            lru_m[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                tag_m[s][w]   = '0;
                valid_m[s][w] = 1'b0;
                dirty_m[s][w] = 1'b0;
            end
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;
        #2;
        check_flag("idle mem_resp", 1'b0, mem_resp);
        check_flag("idle ca_read", 1'b0, ca_read);
        check_flag("idle ca_write", 1'b0, ca_write);

        // Tags A, B, A, C in set 5, then A must hit and B must miss
        wdata = {8{32'h5aa5_c33c}};
        run_access("read A", 1'b0, make_addr(2'd0, 3'd5, 5'd4), '0, '0, missed);
        check_flag("read A misses", 1'b1, missed);
        run_access("read B", 1'b0, make_addr(2'd1, 3'd5, 5'd0), '0, '0, missed);
        check_flag("read B misses", 1'b1, missed);
        run_access("read A again", 1'b0, make_addr(2'd0, 3'd5, 5'd9), '0, '0, missed);
        check_flag("read A again hits", 1'b0, missed);
        run_access("write C", 1'b1, make_addr(2'd2, 3'd5, 5'd0), wdata, 32'h0000_f00f, missed);
        check_flag("write C misses", 1'b1, missed);
        run_access("read A late", 1'b0, make_addr(2'd0, 3'd5, 5'd0), '0, '0, missed);
        check_flag("read A late hits", 1'b0, missed);
        run_access("read B late", 1'b0, make_addr(2'd1, 3'd5, 5'd0), '0, '0, missed);
        check_flag("read B late misses", 1'b1, missed);
        run_access("read C", 1'b0, make_addr(2'd2, 3'd5, 5'd31), '0, '0, missed);

        for (int n = 0; n < num_trans; n++) begin
            for (int w = 0; w < 8; w++) begin
                seed              = next_rand(seed);
                wdata[32*w +: 32] = seed;
            end
            seed = next_rand(seed);
            be   = seed ^ (seed >> 11);
            seed = next_rand(seed);
            run_access($sformatf("random %0d", n), seed[21],
                make_addr(seed[31:30], seed[29:27], seed[26:22]), wdata, be, missed);
        end

        @(negedge clk);
        mem_read  = 1'b0;
        mem_write = 1'b0;
        repeat (4) @(negedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
rtl/cache_pkg.sv
rtl/cache_ctrl_if.sv
rtl/cache_array.sv
rtl/cache_data_array.sv
rtl/cache_datapath.sv
rtl/cache_control.sv
rtl/cache.sv
testbench/cache_mem_model.sv
testbench/cache_tb.sv

//--- Makefile
# Verilator flow for the cache testbench

VERILATOR ?= verilator
TB_TOP    ?= cache_tb
RTL_TOP   ?= cache
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
